/* gat_fixed_pkg.sv */
package gat_fixed_pkg;

  // element and vector sizes
  localparam int DATA_WIDTH = 8;
  localparam int NUM_FEAT   = 8;

  // a full product, then the sum of eight of them with headroom
  localparam int PROD_WIDTH = 16;
  localparam int ACC_WIDTH  = 20;

  // multiply stage plus three adder levels
  localparam int DOT_LATENCY = 4;

  // one signed element of Wh or of the attention vector
  typedef logic signed [DATA_WIDTH-1:0] data_t;

  // one Wh row or one attention half
  typedef data_t [NUM_FEAT-1:0] feat_vec_t;

  // element product
  typedef logic signed [PROD_WIDTH-1:0] prod_t;

  // dot product score
  typedef logic signed [ACC_WIDTH-1:0] acc_t;

  // result of one score lane
  typedef struct packed {
    logic valid;
    acc_t score;
  } lane_res_t;

endpackage

/* gat_wh_pkg.sv */
package gat_wh_pkg;

  import gat_fixed_pkg::*;

  // node count travels with each row
  localparam int NODE_CNT_WIDTH = 5;

  // one projected node word as it arrives
  typedef struct packed {
    feat_vec_t                 features;
    logic [NODE_CNT_WIDTH-1:0] node_cnt;
    logic                      src_flag;
  } wh_word_t;

  // learned attention vector, source half first
  typedef struct packed {
    feat_vec_t a_src;
    feat_vec_t a_nbr;
  } attn_vec_t;

endpackage

/* dmvm_ingress.sv */
`timescale 1ns/100ps

module dmvm_ingress import gat_fixed_pkg::*, gat_wh_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             a_valid_i,
  input  attn_vec_t                        attn_i,
  input  logic                             wh_valid_i,
  input  wh_word_t                         wh_i,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0]  fifo_level_i,
  output logic                             dmvm_ready_o,
  output logic                             src_go_o,
  output logic                             nbr_go_o,
  output feat_vec_t                        feat_o,
  output feat_vec_t                        a_src_o,
  output feat_vec_t                        a_nbr_o,
  output logic                             src_flag_o
);

  // ingress register, the dot pipeline and the combiner register
  localparam int STAGES = DOT_LATENCY + 2;
  localparam int CNT_W  = $clog2(STAGES + 1);
  localparam int SUM_W  = $clog2(FIFO_DEPTH + STAGES + 2);

  logic              accept;
  logic              ready_q;
  logic [STAGES-1:0] flight_q;
  logic [CNT_W-1:0]  flight_cnt_q;
  logic [SUM_W-1:0]  occupancy;

  assign accept       = wh_valid_i && ready_q;
  assign dmvm_ready_o = ready_q;

  // upper bound on what the FIFO has to hold one cycle from now
  assign occupancy = SUM_W'(fifo_level_i) + SUM_W'(flight_cnt_q) + SUM_W'(accept);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q      <= 1'b0;
      flight_q     <= '0;
      flight_cnt_q <= '0;
      src_go_o     <= 1'b0;
      nbr_go_o     <= 1'b0;
    end else begin
      ready_q  <= occupancy < SUM_W'(FIFO_DEPTH);
      flight_q <= {flight_q[STAGES-2:0], accept};
      // a word leaves the count in the cycle it lands in the FIFO
      case ({accept, flight_q[STAGES-1]})
        2'b10:   flight_cnt_q <= flight_cnt_q + 1'b1;
        2'b01:   flight_cnt_q <= flight_cnt_q - 1'b1;
        default: flight_cnt_q <= flight_cnt_q;
      endcase
      src_go_o <= accept && wh_i.src_flag;
      nbr_go_o <= accept;
    end
  end

  // attention halves stay until the next load
  always_ff @(posedge clk) begin
    if (a_valid_i) begin
      a_src_o <= attn_i.a_src;
      a_nbr_o <= attn_i.a_nbr;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      feat_o     <= wh_i.features;
      src_flag_o <= wh_i.src_flag;
    end
  end

  // sender must hold off while ready is low
  assert property (@(posedge clk) disable iff (!rst_n)
    wh_valid_i |-> dmvm_ready_o)
    else $error("wh_valid_i raised while dmvm_ready_o is low");

endmodule

/* attn_dot.sv */
`timescale 1ns/100ps

module attn_dot import gat_fixed_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      go_i,
  input  feat_vec_t a_i,
  input  feat_vec_t feat_i,
  input  logic      flag_i,
  output lane_res_t res_o,
  output logic      flag_o
);

  prod_t                  prod_q [NUM_FEAT];
  acc_t                   lvl1_q [NUM_FEAT/2];
  acc_t                   lvl2_q [NUM_FEAT/4];
  acc_t                   sum_q;
  logic [DOT_LATENCY-1:0] valid_q;
  logic [DOT_LATENCY-1:0] flag_q;

  // valid bit walks alongside the data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[DOT_LATENCY-2:0], go_i};
    end
  end

  always_ff @(posedge clk) begin
    flag_q <= {flag_q[DOT_LATENCY-2:0], flag_i};
  end

  // stage 1 signed products
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_FEAT; k++) begin
      prod_q[k] <= $signed(a_i[k]) * $signed(feat_i[k]);
    end
  end

  // stages 2 to 4 pairwise adder tree
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_FEAT/2; k++) begin
      lvl1_q[k] <= acc_t'(prod_q[2*k]) + acc_t'(prod_q[2*k+1]);
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_FEAT/4; k++) begin
      lvl2_q[k] <= lvl1_q[2*k] + lvl1_q[2*k+1];
    end
  end

  always_ff @(posedge clk) begin
    sum_q <= lvl2_q[0] + lvl2_q[1];
  end

  assign res_o  = '{valid: valid_q[DOT_LATENCY-1], score: sum_q};
  assign flag_o = flag_q[DOT_LATENCY-1];

endmodule

/* coef_combine.sv */
`timescale 1ns/100ps

module coef_combine import gat_fixed_pkg::*; #(
  parameter int FRAC_BITS = 4
) (
  input  logic      clk,
  input  logic      rst_n,
  input  lane_res_t src_res_i,
  input  lane_res_t nbr_res_i,
  input  logic      src_flag_i,
  output logic      push_o,
  output data_t     coef_o
);

  localparam int COEF_MAX = 2**(DATA_WIDTH-1) - 1;

  acc_t                    src_score_q;
  logic                    src_hit;
  logic signed [ACC_WIDTH:0] sum;
  logic signed [ACC_WIDTH:0] scaled;
  data_t                   coef_d;

  // neighbor lane fires on every word, so it paces the combiner
  assign src_hit = nbr_res_i.valid && src_flag_i;

  always_comb begin
    if (src_flag_i) begin
      // self loop
      sum = (ACC_WIDTH+1)'(src_res_i.score) + (ACC_WIDTH+1)'(nbr_res_i.score);
    end else begin
      sum = (ACC_WIDTH+1)'(src_score_q) + (ACC_WIDTH+1)'(nbr_res_i.score);
    end
    scaled = sum >>> FRAC_BITS;
    // clamp into the non-negative half of data_t
    if (scaled < 0) begin
      coef_d = '0;
    end else if (scaled > COEF_MAX) begin
      coef_d = data_t'(COEF_MAX);
    end else begin
      coef_d = data_t'(scaled);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push_o      <= 1'b0;
      src_score_q <= '0;
    end else begin
      push_o <= nbr_res_i.valid;
      if (src_hit) begin
        src_score_q <= src_res_i.score;
      end
    end
  end

  always_ff @(posedge clk) begin
    coef_o <= coef_d;
  end

  // both lanes must line up, a source word drives both
  assert property (@(posedge clk) disable iff (!rst_n)
    src_res_i.valid |-> nbr_res_i.valid)
    else $error("source lane result without neighbor lane result");

  assert property (@(posedge clk) disable iff (!rst_n)
    src_hit |-> src_res_i.valid)
    else $error("flagged word arrived without a source lane result");

endmodule

/* coef_fifo.sv */
`timescale 1ns/100ps

module coef_fifo import gat_fixed_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            push_i,
  input  data_t                           din_i,
  input  logic                            pop_i,
  output data_t                           dout_o,
  output logic                            valid_o,
  output logic [$clog2(FIFO_DEPTH+1)-1:0] level_o
);

  localparam int ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int LVL_W  = $clog2(FIFO_DEPTH + 1);

  data_t             mem [FIFO_DEPTH];
  logic [ADDR_W-1:0] wr_ptr_q;
  logic [ADDR_W-1:0] rd_ptr_q;
  logic [LVL_W-1:0]  level_q;
  logic              do_pop;

  // pop on an empty queue is ignored
  assign do_pop  = pop_i && valid_o;
  assign valid_o = level_q != '0;
  assign dout_o  = mem[rd_ptr_q];
  assign level_o = level_q;

  // wrap explicitly so any depth works
  function automatic logic [ADDR_W-1:0] ptr_inc(input logic [ADDR_W-1:0] ptr);
    if (ptr == ADDR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_i, do_pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= din_i;
    end
  end

  // ingress credit count has to keep this from happening
  assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> level_q < LVL_W'(FIFO_DEPTH))
    else $error("coefficient pushed into a full FIFO");

endmodule

/* dmvm_top.sv */
`timescale 1ns/100ps

module dmvm_top import gat_fixed_pkg::*, gat_wh_pkg::*; #(
  parameter int FIFO_DEPTH = 8,
  parameter int FRAC_BITS  = 4
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      a_valid_i,
  input  attn_vec_t attn_i,
  input  logic      wh_valid_i,
  input  wh_word_t  wh_i,
  output logic      dmvm_ready_o,
  output logic      coef_valid_o,
  output data_t     coef_o,
  input  logic      coef_pop_i
);

  localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

  logic             src_go;
  logic             nbr_go;
  feat_vec_t        feat;
  feat_vec_t        a_src;
  feat_vec_t        a_nbr;
  logic             src_flag;
  lane_res_t        src_res;
  lane_res_t        nbr_res;
  logic             nbr_flag;
  logic             coef_push;
  data_t            coef_din;
  logic [LVL_W-1:0] fifo_level;

  dmvm_ingress #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) ingress0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .a_valid_i   (a_valid_i),
    .attn_i      (attn_i),
    .wh_valid_i  (wh_valid_i),
    .wh_i        (wh_i),
    .fifo_level_i(fifo_level),
    .dmvm_ready_o(dmvm_ready_o),
    .src_go_o    (src_go),
    .nbr_go_o    (nbr_go),
    .feat_o      (feat),
    .a_src_o     (a_src),
    .a_nbr_o     (a_nbr),
    .src_flag_o  (src_flag)
  );

  // source lane only runs on source words
  attn_dot src_dot (
    .clk   (clk),
    .rst_n (rst_n),
    .go_i  (src_go),
    .a_i   (a_src),
    .feat_i(feat),
    .flag_i(1'b0),
    .res_o (src_res),
    .flag_o()
  );

  // neighbor lane runs on every word and carries the source flag
  attn_dot nbr_dot (
    .clk   (clk),
    .rst_n (rst_n),
    .go_i  (nbr_go),
    .a_i   (a_nbr),
    .feat_i(feat),
    .flag_i(src_flag),
    .res_o (nbr_res),
    .flag_o(nbr_flag)
  );

  coef_combine #(
    .FRAC_BITS(FRAC_BITS)
  ) combine0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .src_res_i (src_res),
    .nbr_res_i (nbr_res),
    .src_flag_i(nbr_flag),
    .push_o    (coef_push),
    .coef_o    (coef_din)
  );

  coef_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) fifo0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .push_i (coef_push),
    .din_i  (coef_din),
    .pop_i  (coef_pop_i),
    .dout_o (coef_o),
    .valid_o(coef_valid_o),
    .level_o(fifo_level)
  );

endmodule

/* tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD/2) clk_o = ~clk_o;
  end

  // release just after an edge, away from the sampling point
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2 rst_n_o = 1'b1;
  end

endmodule

/* tb_dmvm.sv */
`timescale 1ns/100ps

module tb_dmvm import gat_fixed_pkg::*, gat_wh_pkg::*; ();

  localparam int FIFO_DEPTH = 8;
  localparam int FRAC_BITS  = 4;
  localparam int MAX_CYCLES = 4000;

  logic      clk;
  logic      rst_n;
  logic      a_valid;
  attn_vec_t attn;
  logic      wh_valid;
  wh_word_t  wh;
  logic      dmvm_ready;
  logic      coef_valid;
  data_t     coef;
  logic      coef_pop;

  int          err_cnt;
  int          check_cnt;
  int          test_cnt;
  int          sent_cnt;
  int          cycle_cnt;
  logic [31:0] lfsr_q;

  // reference model state
  feat_vec_t model_a_src;
  feat_vec_t model_a_nbr;
  int        model_src_score;
  int        exp_q[$];
  wh_word_t  word_q[$];

  tb_clkgen #(.PERIOD(40), .RST_CYCLES(3)) clkgen0 (.clk_o(clk), .rst_n_o(rst_n));

  dmvm_top #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .FRAC_BITS (FRAC_BITS)
  ) dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .a_valid_i   (a_valid),
    .attn_i      (attn),
    .wh_valid_i  (wh_valid),
    .wh_i        (wh),
    .dmvm_ready_o(dmvm_ready),
    .coef_valid_o(coef_valid),
    .coef_o      (coef),
    .coef_pop_i  (coef_pop)
  );

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic signed [31:0] exp_v,
                           input logic signed [31:0] act_v);
    check_cnt++;
    if (exp_v !== act_v) begin
      $display("mismatch %s: expected %0d, actual %0d", name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // signed value of nbits random bits
  function automatic int rand_val(input int nbits);
    int v;
    v = 0;
    for (int i = 0; i < nbits; i++) begin
      v = (v << 1) | int'(next_bit());
    end
    if (v >= (1 << (nbits - 1))) begin
      v = v - (1 << nbits);
    end
    return v;
  endfunction

  function automatic feat_vec_t rand_feat(input int nbits);
    feat_vec_t f;
    for (int k = 0; k < NUM_FEAT; k++) begin
      f[k] = data_t'(rand_val(nbits));
    end
    return f;
  endfunction

  function automatic int dot(input feat_vec_t a, input feat_vec_t f);
    int s;
    s = 0;
    for (int k = 0; k < NUM_FEAT; k++) begin
      s += int'(a[k]) * int'(f[k]);
    end
    return s;
  endfunction

  function automatic int scale_coef(input int sum);
    int s;
    s = sum >>> FRAC_BITS;
    if (s < 0) begin
      return 0;
    end
    if (s > 127) begin
      return 127;
    end
    return s;
  endfunction

  // source words refresh the group score, neighbors reuse it
  function automatic int model_coef(input wh_word_t w);
    int s_src;
    int s_nbr;
    s_nbr = dot(model_a_nbr, w.features);
    if (w.src_flag) begin
      s_src = dot(model_a_src, w.features);
      model_src_score = s_src;
      return scale_coef(s_src + s_nbr);
    end
    return scale_coef(model_src_score + s_nbr);
  endfunction

  function automatic wh_word_t make_word(input feat_vec_t f, input logic src);
    wh_word_t w;
    w.features = f;
    w.node_cnt = NODE_CNT_WIDTH'(7);
    w.src_flag = src;
    return w;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic load_attn(input feat_vec_t a_src, input feat_vec_t a_nbr);
    a_valid     = 1'b1;
    attn.a_src  = a_src;
    attn.a_nbr  = a_nbr;
    model_a_src = a_src;
    model_a_nbr = a_nbr;
    @(posedge clk);
    #2;
    a_valid = 1'b0;
  endtask

  task automatic send_word(input wh_word_t w);
    while (!dmvm_ready) begin
      @(posedge clk);
      #2;
    end
    exp_q.push_back(model_coef(w));
    wh_valid = 1'b1;
    wh       = w;
    @(posedge clk);
    #2;
    wh_valid = 1'b0;
    sent_cnt++;
  endtask

  task automatic send_all();
    while (word_q.size() > 0) begin
      send_word(word_q.pop_front());
    end
  endtask

  task automatic pop_check(input string name, input int n);
    for (int i = 0; i < n; i++) begin
      while (!coef_valid) begin
        @(posedge clk);
        #2;
      end
      check_val(name, exp_q.pop_front(), coef);
      coef_pop = 1'b1;
      @(posedge clk);
      #2;
      coef_pop = 1'b0;
    end
  endtask

  task automatic run_words(input string name);
    int n;
    n = word_q.size();
    fork
      send_all();
      pop_check(name, n);
    join
  endtask

  task automatic finish_test(input string name, input int err_before);
    test_cnt++;
    $display("test %s finished with %0d errors", name, err_cnt - err_before);
  endtask

  task automatic test_reset();
    int e0;
    int i;
    e0 = err_cnt;
    i  = 0;
    // reset just released, no clock edge since
    check_val("reset_ready_low", 0, dmvm_ready);
    check_val("reset_coef_valid", 0, coef_valid);
    @(posedge clk);
    #2;
    while (!dmvm_ready && i < 10) begin
      @(posedge clk);
      #2;
      i++;
    end
    check_val("reset_ready", 1, dmvm_ready);
    finish_test("reset", e0);
  endtask

  task automatic test_self_loop();
    int        e0;
    feat_vec_t a_s;
    feat_vec_t a_n;
    feat_vec_t f;
    e0 = err_cnt;
    for (int k = 0; k < NUM_FEAT; k++) begin
      a_s[k] = data_t'(k + 1);
      a_n[k] = data_t'(2 - k);
      f[k]   = data_t'(3 * k - 5);
    end
    load_attn(a_s, a_n);
    word_q.push_back(make_word(f, 1'b1));
    run_words("self_loop");
    finish_test("self_loop", e0);
  endtask

  task automatic test_groups();
    int e0;
    e0 = err_cnt;
    load_attn(rand_feat(3), rand_feat(3));
    word_q.push_back(make_word(rand_feat(8), 1'b1));
    repeat (4) word_q.push_back(make_word(rand_feat(8), 1'b0));
    // second group replaces the stored score
    word_q.push_back(make_word(rand_feat(8), 1'b1));
    repeat (3) word_q.push_back(make_word(rand_feat(8), 1'b0));
    run_words("groups");
    finish_test("groups", e0);
  endtask

  task automatic test_clamp();
    int        e0;
    feat_vec_t big;
    feat_vec_t neg;
    e0 = err_cnt;
    for (int k = 0; k < NUM_FEAT; k++) begin
      big[k] = data_t'(127);
      neg[k] = data_t'(-128);
    end
    load_attn(big, big);
    word_q.push_back(make_word(big, 1'b1));
    word_q.push_back(make_word(neg, 1'b0));
    word_q.push_back(make_word(neg, 1'b1));
    word_q.push_back(make_word(big, 1'b0));
    run_words("clamp");
    finish_test("clamp", e0);
  endtask

  task automatic test_stream();
    int e0;
    int sent0;
    int n;
    e0    = err_cnt;
    sent0 = sent_cnt;
    load_attn(rand_feat(3), rand_feat(3));
    for (int i = 0; i < 12; i++) begin
      word_q.push_back(make_word(rand_feat(8), (i == 0) || (i == 5)));
    end
    n = word_q.size();
    fork
      send_all();
      begin
        // consumer stalls until the FIFO has filled up
        wait_cycles(30);
        check_val("stream_ready_low", 0, dmvm_ready);
        check_val("stream_held", FIFO_DEPTH, sent_cnt - sent0);
        check_val("stream_valid", 1, coef_valid);
        pop_check("stream", n);
      end
    join
    finish_test("stream", e0);
  endtask

  task automatic test_reload();
    int e0;
    e0 = err_cnt;
    load_attn(rand_feat(3), rand_feat(3));
    word_q.push_back(make_word(rand_feat(8), 1'b1));
    repeat (2) word_q.push_back(make_word(rand_feat(8), 1'b0));
    run_words("reload_a");
    load_attn(rand_feat(3), rand_feat(3));
    word_q.push_back(make_word(rand_feat(8), 1'b1));
    repeat (2) word_q.push_back(make_word(rand_feat(8), 1'b0));
    run_words("reload_b");
    finish_test("reload", e0);
  endtask

  initial begin
    a_valid         = 1'b0;
    attn            = '0;
    wh_valid        = 1'b0;
    wh              = '0;
    coef_pop        = 1'b0;
    err_cnt         = 0;
    check_cnt       = 0;
    test_cnt        = 0;
    sent_cnt        = 0;
    lfsr_q          = 32'hfdb1;
    model_src_score = 0;
    @(posedge rst_n);
    test_reset();
    test_self_loop();
    test_groups();
    test_clamp();
    test_stream();
    test_reload();
    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* sim.f */
gat_fixed_pkg.sv
gat_wh_pkg.sv
dmvm_ingress.sv
attn_dot.sv
coef_combine.sv
coef_fifo.sv
dmvm_top.sv
tb_clkgen.sv
tb_dmvm.sv
